//--- cop_pkg.sv
package cop_pkg;

    // cpu bus geometry, fixed by the 68000
    localparam int ADDR_W = 23;     // word address, A23..A1
    localparam int DATA_W = 16;

    // tile chip positions in the one-hot tile_cs vector
    localparam int TILE_B = 0;      // first background chip
    localparam int TILE_C = 1;      // second background chip
    localparam int TILE_F = 2;      // foreground chip

    // region decoded for the cycle in progress
    typedef enum logic [3:0] {
        reg_none,       // nothing mapped, bus error after time-out
        reg_rom,        // program rom, reads only
        reg_sysram,     // work ram, on chip
        reg_obj,        // object ram
        reg_pal,        // palette
        reg_prisel,     // layer priority
        reg_io,         // cabinet page, on chip
        reg_snd,        // sound latch
        reg_tile        // one of the three tile chips
    } cop_region_e;

    // register group inside a tile chip
    // order follows the offset within the chip window
    typedef enum logic [1:0] {
        tile_mode,      // control registers
        tile_map,       // tilemap ram
        tile_sft,       // row/col scroll ram
        tile_none
    } tile_reg_e;

    // word slot on the i/o page, straight from A[3:1]
    typedef enum logic [2:0] {
        io_cabinet = 3'd0,  // joysticks
        io_dip     = 3'd1,  // dip switches
        io_rot0    = 3'd2,  // rotary, player 1
        io_rot1    = 3'd3,  // rotary, player 2
        io_system  = 3'd4,  // coin, service, vblank
        io_vclr    = 3'd5   // vblank irq acknowledge
    } io_reg_e;

endpackage

//--- cop_decoder.sv
`timescale 1ns/1ps

module cop_decoder (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [cop_pkg::ADDR_W:1] addr,
    input  logic                     as_n,
    input  logic                     rnw,
    output cop_pkg::cop_region_e     region,
    output logic [2:0]               tile_cs,
    output cop_pkg::tile_reg_e       tile_reg,
    output cop_pkg::io_reg_e         io_sel,
    output logic                     busy
);
    import cop_pkg::*;

    cop_region_e dec_region;
    logic [2:0]  dec_tile_cs;
    tile_reg_e   dec_tile_reg;
    logic        io_ok;     // io page hit on a defined slot
    logic        grp_ok;    // tile group offset is 0..2

    // A23/A22 not decoded, the map mirrors over them
    assign io_ok  = !addr[4] && (addr[3:1] <= 3'd5);
    assign grp_ok = addr[18:17] != 2'd3;  // offsets 3 and 7 are holes

    // the whole memory map, in one place
    always_comb begin
        dec_region   = reg_none;
        dec_tile_cs  = '0;
        dec_tile_reg = tile_none;
        case (addr[21:20])
            2'd0: begin
                // rom only half populated, writes fall through to berr
                if (rnw && addr[19:16] < 4'd8) begin
                    dec_region = reg_rom;
                end
            end
            2'd1: begin
                case (addr[19:17])
                    3'd0: dec_region = reg_sysram;  // 10'0000
                    3'd1: dec_region = reg_obj;     // 12'0000
                    3'd2: dec_region = reg_pal;     // 14'0000
                    3'd3: dec_region = reg_prisel;  // 16'0000
                    3'd4: begin                     // 18'0000
                        if (io_ok) begin
                            dec_region = reg_io;
                        end
                    end
                    3'd5: dec_region = reg_snd;     // 1a'0000
                    default: ;                      // 1c, 1e unmapped
                endcase
            end
            2'd2: begin
                // chip b in the low half, chip c in the high half
                if (grp_ok) begin
                    dec_region   = reg_tile;
                    dec_tile_reg = tile_reg_e'(addr[18:17]);
                    if (addr[19]) begin
                        dec_tile_cs[TILE_C] = 1'b1;
                    end else begin
                        dec_tile_cs[TILE_B] = 1'b1;
                    end
                end
            end
            default: begin
                // chip f, low half only
                if (grp_ok && !addr[19]) begin
                    dec_region          = reg_tile;
                    dec_tile_reg        = tile_reg_e'(addr[18:17]);
                    dec_tile_cs[TILE_F] = 1'b1;
                end
            end
        endcase
    end

    // capture on the first low strobe, hold until strobe seen high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            region   <= reg_none;
            tile_cs  <= '0;
            tile_reg <= tile_none;
            io_sel   <= io_cabinet;
        end else if (!busy) begin
            if (!as_n) begin
                busy     <= 1'b1;
                region   <= dec_region;
                tile_cs  <= dec_tile_cs;
                tile_reg <= dec_tile_reg;
                io_sel   <= io_reg_e'(addr[3:1]);  // only meaningful with reg_io
            end
        end else if (as_n) begin
            // release edge, selects drop with the acknowledge
            busy     <= 1'b0;
            region   <= reg_none;
            tile_cs  <= '0;
            tile_reg <= tile_none;
        end
    end

endmodule

//--- cop_sysram.sv
`timescale 1ns/1ps

module cop_sysram #(
    parameter int SYSRAM_AW = 12   // word address bits, up to 16
) (
    input  logic                       clk,
    input  logic                       sel,
    input  logic                       we,
    input  logic                       uds_n,
    input  logic                       lds_n,
    input  logic [SYSRAM_AW-1:0]       addr,
    input  logic [cop_pkg::DATA_W-1:0] din,
    output logic [cop_pkg::DATA_W-1:0] dout
);
    import cop_pkg::*;

    localparam int DEPTH = 1 << SYSRAM_AW;
    localparam int HALF  = DATA_W / 2;

    // two byte lanes kept apart so each maps to its own ram block
    logic [HALF-1:0] mem_hi [DEPTH];
    logic [HALF-1:0] mem_lo [DEPTH];

    logic wr_hi;
    logic wr_lo;

    assign wr_hi = sel && we && !uds_n;   // D15..D8
    assign wr_lo = sel && we && !lds_n;   // D7..D0

    always_ff @(posedge clk) begin
        if (wr_hi) begin
            mem_hi[addr] <= din[DATA_W-1:HALF];
        end
        if (wr_lo) begin
            mem_lo[addr] <= din[HALF-1:0];
        end
    end

    // registered read, one clock behind the select
    // both lanes always read, the cpu picks its byte
    always_ff @(posedge clk) begin
        if (sel) begin
            dout <= {mem_hi[addr], mem_lo[addr]};
        end
    end

endmodule

//--- cop_io.sv
`timescale 1ns/1ps

module cop_io (
    input  logic                       clk,
    input  logic                       arst_n,
    input  cop_pkg::io_reg_e           io_sel,
    input  logic                       io_hit,
    input  logic                       lvbl,
    input  logic [cop_pkg::DATA_W-1:0] joy,
    input  logic [cop_pkg::DATA_W-1:0] dip,
    input  logic [cop_pkg::DATA_W-1:0] rot0,
    input  logic [cop_pkg::DATA_W-1:0] rot1,
    input  logic                       service,
    input  logic                       sec2,
    input  logic [1:0]                 coin,
    output logic [cop_pkg::DATA_W-1:0] dout,
    output logic                       irq_n,
    output logic                       obj_copy
);
    import cop_pkg::*;

    logic [DATA_W-1:0] sys_word;
    logic              lvbl_l;     // lvbl one clock back
    logic              vb_start;   // blanking just began
    logic              vclr_hit;

    // system word: lvbl on bit 7, coin and service in 5:0
    assign sys_word = {{(DATA_W-8){1'b0}}, lvbl, 1'b0, service, coin, sec2, 2'b00};

    assign vb_start = lvbl_l && !lvbl;
    assign vclr_hit = io_hit && (io_sel == io_vclr);

    // read mux, decoder keeps io_sel stable through the cycle
    always_comb begin
        case (io_sel)
            io_cabinet: dout = joy;
            io_dip:     dout = dip;
            io_rot0:    dout = rot0;
            io_rot1:    dout = rot1;
            io_system:  dout = sys_word;
            default:    dout = '0;  // vclr slot reads back zero
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lvbl_l   <= 1'b1;   // assume active video out of reset
            irq_n    <= 1'b1;
            obj_copy <= 1'b0;
        end else begin
            lvbl_l   <= lvbl;
            obj_copy <= vb_start;   // one pulse per frame, called DM on the pcb
            if (vb_start) begin
                irq_n <= 1'b0;      // a new frame wins over a late clear
            end else if (vclr_hit) begin
                irq_n <= 1'b1;      // any access to 18'000a acks it
            end
        end
    end

endmodule

//--- cop_bus_ctrl.sv
`timescale 1ns/1ps

module cop_bus_ctrl #(
    parameter int BERR_CYCLES = 8   // clocks to bus error, keep above 2
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       as_n,
    input  logic                       busy,
    input  cop_pkg::cop_region_e       region,
    input  logic [cop_pkg::DATA_W-1:0] ram_dout,
    input  logic [cop_pkg::DATA_W-1:0] io_dout,
    input  logic [cop_pkg::DATA_W-1:0] ext_din,
    output logic [cop_pkg::DATA_W-1:0] dout,
    output logic                       dtack_n,
    output logic                       berr_n,
    output logic                       ack_stb
);
    import cop_pkg::*;

    localparam int ACK_CYCLES = 2;  // mapped regions answer after two clocks
    localparam int CNT_W      = $clog2(BERR_CYCLES + 1);

    logic [CNT_W-1:0] cnt;      // clocks since the decode edge
    logic [CNT_W-1:0] cnt_nxt;
    logic             done;     // cycle answered, waiting for release
    logic             active;   // counting this clock
    logic             berr_stb;

    assign cnt_nxt  = cnt + 1'b1;
    assign active   = busy && !as_n && !done;
    // ram writes on this same edge
    assign ack_stb  = active && (region != reg_none) && (cnt_nxt == CNT_W'(ACK_CYCLES));
    assign berr_stb = active && (region == reg_none) && (cnt_nxt == CNT_W'(BERR_CYCLES));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt     <= '0;
            done    <= 1'b0;
            dtack_n <= 1'b1;
            berr_n  <= 1'b1;
        end else if (busy && as_n) begin
            // strobe seen high, drop everything
            cnt     <= '0;
            done    <= 1'b0;
            dtack_n <= 1'b1;
            berr_n  <= 1'b1;
        end else if (active) begin
            cnt <= cnt_nxt;
            if (ack_stb) begin
                dtack_n <= 1'b0;
                done    <= 1'b1;
            end
            if (berr_stb) begin
                berr_n <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    // read data captured with the acknowledge
    always_ff @(posedge clk) begin
        if (ack_stb) begin
            case (region)
                reg_sysram: dout <= ram_dout;
                reg_io:     dout <= io_dout;
                default:    dout <= ext_din;    // rom, obj, pal, tiles...
            endcase
        end
    end

endmodule

//--- cop_main_bus.sv
`timescale 1ns/1ps

module cop_main_bus #(
    parameter int SYSRAM_AW   = 12,
    parameter int BERR_CYCLES = 8
) (
    input  logic                       clk,
    input  logic                       arst_n,
    // cpu bus
    input  logic [cop_pkg::ADDR_W:1]   addr,
    input  logic                       as_n,
    input  logic                       rnw,
    input  logic                       uds_n,
    input  logic                       lds_n,
    input  logic [cop_pkg::DATA_W-1:0] din,
    output logic [cop_pkg::DATA_W-1:0] dout,
    output logic                       dtack_n,
    output logic                       berr_n,
    // off-chip regions
    output logic                       rom_cs,
    output logic                       obj_cs,
    output logic                       pal_cs,
    output logic                       prisel_cs,
    output logic                       snreq,
    output logic [2:0]                 tile_cs,     // chips b, c, f
    output cop_pkg::tile_reg_e         tile_reg,
    input  logic [cop_pkg::DATA_W-1:0] ext_din,
    // video and cabinet
    input  logic                       lvbl,
    input  logic [cop_pkg::DATA_W-1:0] joy,
    input  logic [cop_pkg::DATA_W-1:0] dip,
    input  logic [cop_pkg::DATA_W-1:0] rot0,
    input  logic [cop_pkg::DATA_W-1:0] rot1,
    input  logic                       service,
    input  logic [1:0]                 coin,
    input  logic                       sec2,
    output logic                       irq_n,
    output logic                       obj_copy
);
    import cop_pkg::*;

    cop_region_e       region;
    io_reg_e           io_sel;
    logic              busy;
    logic              ack_stb;
    logic [DATA_W-1:0] ram_dout;
    logic [DATA_W-1:0] io_dout;

    // region enum fanned out to the external chips
    assign rom_cs    = region == reg_rom;
    assign obj_cs    = region == reg_obj;
    assign pal_cs    = region == reg_pal;
    assign prisel_cs = region == reg_prisel;
    assign snreq     = region == reg_snd;

    cop_decoder i_cop_decoder (
        .clk      (clk),
        .arst_n   (arst_n),
        .addr     (addr),
        .as_n     (as_n),
        .rnw      (rnw),
        .region   (region),
        .tile_cs  (tile_cs),
        .tile_reg (tile_reg),
        .io_sel   (io_sel),
        .busy     (busy)
    );

    cop_sysram #(
        .SYSRAM_AW (SYSRAM_AW)
    ) i_cop_sysram (
        .clk   (clk),
        .sel   (region == reg_sysram),
        .we    (ack_stb && !rnw),       // write lands on the dtack edge
        .uds_n (uds_n),
        .lds_n (lds_n),
        .addr  (addr[SYSRAM_AW:1]),
        .din   (din),
        .dout  (ram_dout)
    );

    cop_io i_cop_io (
        .clk      (clk),
        .arst_n   (arst_n),
        .io_sel   (io_sel),
        .io_hit   (region == reg_io),
        .lvbl     (lvbl),
        .joy      (joy),
        .dip      (dip),
        .rot0     (rot0),
        .rot1     (rot1),
        .service  (service),
        .sec2     (sec2),
        .coin     (coin),
        .dout     (io_dout),
        .irq_n    (irq_n),
        .obj_copy (obj_copy)
    );

    cop_bus_ctrl #(
        .BERR_CYCLES (BERR_CYCLES)
    ) i_cop_bus_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .as_n     (as_n),
        .busy     (busy),
        .region   (region),
        .ram_dout (ram_dout),
        .io_dout  (io_dout),
        .ext_din  (ext_din),
        .dout     (dout),
        .dtack_n  (dtack_n),
        .berr_n   (berr_n),
        .ack_stb  (ack_stb)
    );

endmodule

//--- cop_tb.sv
`timescale 1ns/1ps

module cop_tb;
    import cop_pkg::*;

    localparam int SYSRAM_AW   = 12;
    localparam int BERR_CYCLES = 8;
    localparam int SEED        = 91352;
    localparam int ACK_LIMIT   = BERR_CYCLES + 8;  // negedges before giving up on an ack
    localparam int REL_LIMIT   = 6;

    // what a row expects back
    localparam int SRC_NONE  = 0;   // write or no data check
    localparam int SRC_EXT   = 1;   // ext_din passed through
    localparam int SRC_RAM   = 2;   // ram model word
    localparam int SRC_IO    = 3;   // cabinet word for the slot
    localparam int SRC_BERR  = 4;   // unmapped, bus error
    localparam int SRC_RAMWR = 5;   // write that updates the ram model

    // select vector layout {tile f, c, b, snreq, prisel, pal, obj, rom}
    localparam logic [7:0] SEL_ROM = 8'h01;
    localparam logic [7:0] SEL_OBJ = 8'h02;
    localparam logic [7:0] SEL_PAL = 8'h04;
    localparam logic [7:0] SEL_PRI = 8'h08;
    localparam logic [7:0] SEL_SND = 8'h10;
    localparam logic [7:0] SEL_TB  = 8'h20;
    localparam logic [7:0] SEL_TC  = 8'h40;
    localparam logic [7:0] SEL_TF  = 8'h80;
    localparam logic [1:0] TR_NONE = 2'd3;

    logic              clk = 1'b0;
    logic              arst_n;
    logic [ADDR_W:1]   addr;
    logic              as_n;
    logic              rnw;
    logic              uds_n;
    logic              lds_n;
    logic [DATA_W-1:0] din;
    logic [DATA_W-1:0] dout;
    logic              dtack_n;
    logic              berr_n;
    logic              rom_cs;
    logic              obj_cs;
    logic              pal_cs;
    logic              prisel_cs;
    logic              snreq;
    logic [2:0]        tile_cs;
    tile_reg_e         tile_reg;
    logic [DATA_W-1:0] ext_din;
    logic              lvbl;
    logic [DATA_W-1:0] joy;
    logic [DATA_W-1:0] dip;
    logic [DATA_W-1:0] rot0;
    logic [DATA_W-1:0] rot1;
    logic              service;
    logic [1:0]        coin;
    logic              sec2;
    logic              irq_n;
    logic              obj_copy;
    logic [7:0]        sel_vec;

    // stimulus table, one entry per bus cycle
    string       t_name[$];
    logic [23:0] t_addr[$];    // byte address, A0 dropped on the bus
    logic        t_rnw[$];
    logic [1:0]  t_strb[$];    // {uds_n, lds_n}
    logic [15:0] t_wdata[$];
    logic [7:0]  t_sel[$];
    logic [1:0]  t_treg[$];
    int          t_src[$];

    logic [15:0] ram_model [1 << SYSRAM_AW];
    int          mismatches = 0;
    int          timeouts   = 0;

    assign sel_vec = {tile_cs, snreq, prisel_cs, pal_cs, obj_cs, rom_cs};

    always #20 clk = ~clk;

    cop_main_bus #(
        .SYSRAM_AW   (SYSRAM_AW),
        .BERR_CYCLES (BERR_CYCLES)
    ) i_cop_main_bus (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (addr),
        .as_n      (as_n),
        .rnw       (rnw),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .din       (din),
        .dout      (dout),
        .dtack_n   (dtack_n),
        .berr_n    (berr_n),
        .rom_cs    (rom_cs),
        .obj_cs    (obj_cs),
        .pal_cs    (pal_cs),
        .prisel_cs (prisel_cs),
        .snreq     (snreq),
        .tile_cs   (tile_cs),
        .tile_reg  (tile_reg),
        .ext_din   (ext_din),
        .lvbl      (lvbl),
        .joy       (joy),
        .dip       (dip),
        .rot0      (rot0),
        .rot1      (rot1),
        .service   (service),
        .coin      (coin),
        .sec2      (sec2),
        .irq_n     (irq_n),
        .obj_copy  (obj_copy)
    );

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            mismatches++;
            $display("mismatch %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic add_row(input string name, input logic [23:0] baddr, input logic wr_n,
                           input logic [1:0] strb, input logic [7:0] sel,
                           input logic [1:0] treg, input int src);
        t_name.push_back(name);
        t_addr.push_back(baddr);
        t_rnw.push_back(wr_n);
        t_strb.push_back(strb);
        t_wdata.push_back(16'($urandom));   // random write data
        t_sel.push_back(sel);
        t_treg.push_back(treg);
        t_src.push_back(src);
    endtask

    // cabinet word per slot, system word as {lvbl, 0, service, coin, sec2, 00}
    function automatic logic [15:0] io_expect(input logic [2:0] slot);
        case (slot)
            3'd0:    return joy;
            3'd1:    return dip;
            3'd2:    return rot0;
            3'd3:    return rot1;
            3'd4:    return {8'h00, lvbl, 1'b0, service, coin, sec2, 2'b00};
            default: return 16'h0000;
        endcase
    endfunction

    // one full four-phase cycle, results sampled on the ack negedge
    task automatic bus_cycle(input string name, input logic [23:0] baddr, input logic wr_n,
                             input logic [1:0] strb, input logic [15:0] wdata,
                             input logic [15:0] ext_val, output logic [7:0] sel_seen,
                             output logic [1:0] treg_seen, output logic [15:0] rdata,
                             output logic dt_seen, output logic be_seen,
                             output int lat, output int rel);
        int n;
        @(posedge clk);
        addr           <= baddr[23:1];
        rnw            <= wr_n;
        {uds_n, lds_n} <= strb;
        din            <= wdata;
        ext_din        <= ext_val;
        as_n           <= 1'b0;
        n = 0;
        while (n < ACK_LIMIT && dtack_n && berr_n) begin
            @(negedge clk);
            n++;
        end
        if (dtack_n && berr_n) begin
            timeouts++;
            $display("no acknowledge for cycle %s", name);
        end
        lat       = n;              // negedges since the strobe went low
        sel_seen  = sel_vec;
        treg_seen = tile_reg;
        rdata     = dout;
        dt_seen   = dtack_n;
        be_seen   = berr_n;
        @(posedge clk);
        as_n           <= 1'b1;
        rnw            <= 1'b1;
        {uds_n, lds_n} <= 2'b11;
        n = 0;
        while (n < REL_LIMIT && !(dtack_n && berr_n)) begin
            @(negedge clk);
            n++;
        end
        if (!(dtack_n && berr_n)) begin
            timeouts++;
            $display("acknowledge never released for cycle %s", name);
        end
        rel = n;
    endtask

    task automatic apply_row(input int i);
        logic [7:0]  sel_seen;
        logic [1:0]  treg_seen;
        logic [15:0] rdata;
        logic [15:0] ext_val;
        logic [23:0] baddr;
        logic [1:0]  strb;
        logic [15:0] wdata;
        logic        dt_seen;
        logic        be_seen;
        int          lat;
        int          rel;
        string       nm;
        ext_val = 16'($urandom);
        baddr   = t_addr[i];
        strb    = t_strb[i];
        wdata   = t_wdata[i];
        nm      = t_name[i];
        bus_cycle(nm, baddr, t_rnw[i], strb, wdata, ext_val, sel_seen, treg_seen, rdata,
                  dt_seen, be_seen, lat, rel);
        check({nm, " selects"}, 32'(t_sel[i]), 32'(sel_seen));
        check({nm, " tile_reg"}, 32'(t_treg[i]), 32'(treg_seen));
        check({nm, " release"}, 2, rel);   // strobe up, then one edge
        // lat also holds the negedge before the decode edge and the one after the ack
        if (t_src[i] == SRC_BERR) begin
            check({nm, " berr_n"}, 0, 32'(be_seen));
            check({nm, " dtack_n"}, 1, 32'(dt_seen));
            check({nm, " berr clocks"}, BERR_CYCLES, lat - 2);
        end else begin
            check({nm, " dtack_n"}, 0, 32'(dt_seen));
            check({nm, " berr_n"}, 1, 32'(be_seen));
            check({nm, " ack clocks"}, 2, lat - 2);
        end
        case (t_src[i])
            SRC_EXT: check({nm, " data"}, 32'(ext_val), 32'(rdata));
            SRC_RAM: check({nm, " data"}, 32'(ram_model[baddr[12:1]]), 32'(rdata));
            SRC_IO:  check({nm, " data"}, 32'(io_expect(baddr[3:1])), 32'(rdata));
            SRC_RAMWR: begin
                if (!strb[1]) ram_model[baddr[12:1]][15:8] = wdata[15:8];  // uds lane
                if (!strb[0]) ram_model[baddr[12:1]][7:0]  = wdata[7:0];   // lds lane
            end
            default: ;
        endcase
    endtask

    task automatic build_table();
        add_row("rom_lo",      24'h000000, 1'b1, 2'b00, SEL_ROM, TR_NONE, SRC_EXT);
        add_row("rom_7",       24'h07fffe, 1'b1, 2'b00, SEL_ROM, TR_NONE, SRC_EXT);
        add_row("rom_8",       24'h080000, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("rom_wr",      24'h000100, 1'b0, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("ram_wr_both", 24'h100010, 1'b0, 2'b00, 8'h00,   TR_NONE, SRC_RAMWR);
        add_row("ram_rd_both", 24'h100010, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_RAM);
        add_row("ram_wr_hi",   24'h100010, 1'b0, 2'b01, 8'h00,   TR_NONE, SRC_RAMWR);
        add_row("ram_rd_hi",   24'h100010, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_RAM);
        add_row("ram_wr_lo",   24'h100010, 1'b0, 2'b10, 8'h00,   TR_NONE, SRC_RAMWR);
        add_row("ram_rd_lo",   24'h100010, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_RAM);
        add_row("ram_wr_top",  24'h101ffe, 1'b0, 2'b00, 8'h00,   TR_NONE, SRC_RAMWR);
        add_row("ram_rd_top",  24'h101ffe, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_RAM);
        add_row("ram_rd_back", 24'h100010, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_RAM);
        add_row("obj_rd",      24'h120000, 1'b1, 2'b00, SEL_OBJ, TR_NONE, SRC_EXT);
        add_row("pal_rd",      24'h140000, 1'b1, 2'b00, SEL_PAL, TR_NONE, SRC_EXT);
        add_row("prisel_wr",   24'h160000, 1'b0, 2'b00, SEL_PRI, TR_NONE, SRC_NONE);
        add_row("snd_wr",      24'h1a0000, 1'b0, 2'b10, SEL_SND, TR_NONE, SRC_NONE);
        add_row("io_cabinet",  24'h180000, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_IO);
        add_row("io_dip",      24'h180002, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_IO);
        add_row("io_rot0",     24'h180004, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_IO);
        add_row("io_rot1",     24'h180006, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_IO);
        add_row("io_system",   24'h180008, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_IO);
        add_row("io_slot6",    24'h18000c, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("io_a4",       24'h180010, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("page_1c",     24'h1c0000, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("tb_mode",     24'h200000, 1'b1, 2'b00, SEL_TB,  2'd0,    SRC_EXT);
        add_row("tb_map",      24'h220000, 1'b1, 2'b00, SEL_TB,  2'd1,    SRC_EXT);
        add_row("tb_sft",      24'h240000, 1'b0, 2'b00, SEL_TB,  2'd2,    SRC_NONE);
        add_row("tb_off3",     24'h260000, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("tc_mode",     24'h280000, 1'b1, 2'b00, SEL_TC,  2'd0,    SRC_EXT);
        add_row("tc_map",      24'h2a0000, 1'b0, 2'b00, SEL_TC,  2'd1,    SRC_NONE);
        add_row("tc_sft",      24'h2c0000, 1'b1, 2'b00, SEL_TC,  2'd2,    SRC_EXT);
        add_row("tc_off7",     24'h2e0000, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("tf_mode",     24'h300000, 1'b0, 2'b00, SEL_TF,  2'd0,    SRC_NONE);
        add_row("tf_map",      24'h320000, 1'b1, 2'b00, SEL_TF,  2'd1,    SRC_EXT);
        add_row("tf_sft",      24'h340000, 1'b1, 2'b00, SEL_TF,  2'd2,    SRC_EXT);
        add_row("tf_off3",     24'h360000, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
        add_row("tf_high",     24'h380000, 1'b1, 2'b00, 8'h00,   TR_NONE, SRC_BERR);
    endtask

    initial begin
        logic [7:0]  sel_seen;
        logic [1:0]  treg_seen;
        logic [15:0] rdata;
        logic        dt_seen;
        logic        be_seen;
        int          lat;
        int          rel;
        int          pulses;
        int          irq_at;
        int          copy_at;
        void'($urandom(SEED));
        arst_n  <= 1'b0;
        addr    <= '0;
        as_n    <= 1'b1;
        rnw     <= 1'b1;
        uds_n   <= 1'b1;
        lds_n   <= 1'b1;
        din     <= '0;
        ext_din <= '0;
        lvbl    <= 1'b1;            // active video
        joy     <= 16'($urandom);
        dip     <= 16'($urandom);
        rot0    <= 16'($urandom);
        rot1    <= 16'($urandom);
        service <= 1'($urandom);
        coin    <= 2'($urandom);
        sec2    <= 1'($urandom);
        build_table();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("reset dtack_n", 1, 32'(dtack_n));
        check("reset berr_n", 1, 32'(berr_n));
        check("reset irq_n", 1, 32'(irq_n));
        check("reset selects", 0, 32'(sel_vec));
        check("reset obj_copy", 0, 32'(obj_copy));

        for (int i = 0; i < t_name.size(); i++) begin
            apply_row(i);
        end

        // blanking starts, lvbl held low for a while
        @(posedge clk);
        lvbl <= 1'b0;
        pulses  = 0;
        irq_at  = 0;
        copy_at = 0;
        for (int n = 1; n <= 12; n++) begin
            @(negedge clk);
            if (obj_copy) pulses++;
            if (obj_copy && copy_at == 0) copy_at = n;
            if (!irq_n && irq_at == 0) irq_at = n;
        end
        // first edge seeing lvbl low comes before the second negedge
        check("vblank obj_copy pulses", 1, pulses);
        check("vblank irq edge", 2, irq_at);
        check("vblank obj_copy edge", 2, copy_at);
        check("vblank irq_n", 0, 32'(irq_n));
        // system word shows lvbl low, irq stays pending
        bus_cycle("io_system_vb", 24'h180008, 1'b1, 2'b00, 16'h0000, 16'h0000, sel_seen,
                  treg_seen, rdata, dt_seen, be_seen, lat, rel);
        check("io_system_vb data", 32'(io_expect(3'd4)), 32'(rdata));
        check("io_system_vb irq_n", 0, 32'(irq_n));
        bus_cycle("io_vclr", 24'h18000a, 1'b1, 2'b00, 16'h0000, 16'h0000, sel_seen,
                  treg_seen, rdata, dt_seen, be_seen, lat, rel);
        check("io_vclr dtack_n", 0, 32'(dt_seen));
        check("io_vclr irq_n", 1, 32'(irq_n));
        @(posedge clk);
        lvbl <= 1'b1;
        pulses = 0;
        for (int n = 0; n < 4; n++) begin
            @(negedge clk);
            if (obj_copy) pulses++;
        end
        check("vblank end obj_copy", 0, pulses);  // rising lvbl gives nothing

        $display("checks done, %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
cop_pkg.sv
cop_decoder.sv
cop_sysram.sv
cop_io.sv
cop_bus_ctrl.sv
cop_main_bus.sv
cop_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the cop bus testbench with verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module cop_tb -o cop_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cop_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi

exit 0
